// ==== design/rv_isa_pkg.sv ====
package rv_isa_pkg;

	// Data path and instruction width
	localparam int XLEN = 32;

	localparam int REG_ADDR_W = 5;
	localparam int NUM_REGS = 32;

	// Major opcodes, bits [6:0] of the instruction word
	typedef enum logic [6:0] {
		OPC_LUI      = 7'b0110111,
		OPC_AUIPC    = 7'b0010111,
		OPC_JAL      = 7'b1101111,
		OPC_JALR     = 7'b1100111,
		OPC_BRANCH   = 7'b1100011,
		OPC_LOAD     = 7'b0000011,
		OPC_STORE    = 7'b0100011,
		OPC_OP_IMM   = 7'b0010011,
		OPC_OP       = 7'b0110011,
		OPC_MISC_MEM = 7'b0001111,
		OPC_SYSTEM   = 7'b1110011
	} opcode_e;

	// ALU function codes for OP and OP-IMM
	typedef enum logic [2:0] {
		F3_ADD  = 3'b000,
		F3_SLL  = 3'b001,
		F3_SLT  = 3'b010,
		F3_SLTU = 3'b011,
		F3_XOR  = 3'b100,
		F3_SRL  = 3'b101,
		F3_OR   = 3'b110,
		F3_AND  = 3'b111
	} funct3_e;

	// Selects SUB over ADD and SRA over SRL
	localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

endpackage

// ==== design/core_pkg.sv ====
package core_pkg;

	typedef enum logic [3:0] {
		ALU_ADD    = 4'd0,
		ALU_SUB    = 4'd1,
		ALU_SLL    = 4'd2,
		ALU_SLT    = 4'd3,
		ALU_SLTU   = 4'd4,
		ALU_XOR    = 4'd5,
		ALU_SRL    = 4'd6,
		ALU_SRA    = 4'd7,
		ALU_OR     = 4'd8,
		ALU_AND    = 4'd9,
		ALU_PASS_B = 4'd10
	} alu_op_e;

	// Retire handshake states of the execute unit
	typedef enum logic [1:0] {
		IDLE     = 2'd0,
		REQ      = 2'd1,
		WAIT_LOW = 2'd2
	} exec_state_e;

	// Decoded-operation buffer
	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_PTR_W = 2;

endpackage

// ==== design/alu.sv ====
`timescale 1ns/1ps

module alu import rv_isa_pkg::*, core_pkg::*; (
	input  alu_op_e         op,
	input  logic [XLEN-1:0] a,
	input  logic [XLEN-1:0] b,
	output logic [XLEN-1:0] result
);

	logic [$clog2(XLEN)-1:0] shamt;

	assign shamt = b[$clog2(XLEN)-1:0];

	always_comb begin
		case (op)
			ALU_ADD:    result = a + b;
			ALU_SUB:    result = a - b;
			ALU_SLL:    result = a << shamt;
			ALU_SLT:    result = XLEN'($signed(a) < $signed(b));
			ALU_SLTU:   result = XLEN'(a < b);
			ALU_XOR:    result = a ^ b;
			ALU_SRL:    result = a >> shamt;
			// Arithmetic shift keeps the sign
			ALU_SRA:    result = $unsigned($signed(a) >>> shamt);
			ALU_OR:     result = a | b;
			ALU_AND:    result = a & b;
			ALU_PASS_B: result = b;
			default:    result = '0;
		endcase
	end

endmodule

// ==== design/reg_file.sv ====
`timescale 1ns/1ps

module reg_file import rv_isa_pkg::*; (
	input  logic                  clk,
	input  logic                  reset,
	input  logic [REG_ADDR_W-1:0] rs1,
	input  logic [REG_ADDR_W-1:0] rs2,
	output logic [XLEN-1:0]       rdata1,
	output logic [XLEN-1:0]       rdata2,
	input  logic                  we,
	input  logic [REG_ADDR_W-1:0] waddr,
	input  logic [XLEN-1:0]       wdata
);

	logic [XLEN-1:0] regs [NUM_REGS];

	// x0 is never written, so it reads zero
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (we && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	assign rdata1 = regs[rs1];
	assign rdata2 = regs[rs2];

endmodule

// ==== design/inst_decoder.sv ====
`timescale 1ns/1ps

module inst_decoder import rv_isa_pkg::*, core_pkg::*; (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  inst_req,
	input  logic [XLEN-1:0]       inst_word,
	output logic                  inst_ack,
	input  logic                  full,
	output logic                  push,
	output logic [XLEN-1:0]       op_pc,
	output logic [REG_ADDR_W-1:0] op_rd,
	output logic [REG_ADDR_W-1:0] op_rs1,
	output logic [REG_ADDR_W-1:0] op_rs2,
	output logic [XLEN-1:0]       op_imm,
	output alu_op_e               op_alu,
	output logic                  op_use_imm,
	output logic                  op_use_pc,
	output logic                  op_illegal
);

	logic [XLEN-1:0] pc;
	logic accept;

	opcode_e opcode;
	funct3_e funct3;
	logic [6:0] funct7;
	logic f7_zero;
	logic f7_alt;
	logic [XLEN-1:0] imm_i;
	logic [XLEN-1:0] imm_u;

	alu_op_e dec_alu;
	logic [XLEN-1:0] dec_imm;
	logic [REG_ADDR_W-1:0] dec_rs1;
	logic dec_use_imm;
	logic dec_use_pc;
	logic dec_illegal;

	function automatic alu_op_e f3_to_alu(input funct3_e f3, input logic alt);
		case (f3)
			F3_ADD:  return alt ? ALU_SUB : ALU_ADD;
			F3_SLL:  return ALU_SLL;
			F3_SLT:  return ALU_SLT;
			F3_SLTU: return ALU_SLTU;
			F3_XOR:  return ALU_XOR;
			F3_SRL:  return alt ? ALU_SRA : ALU_SRL;
			F3_OR:   return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	assign opcode = opcode_e'(inst_word[6:0]);
	assign funct3 = funct3_e'(inst_word[14:12]);
	assign funct7 = inst_word[31:25];
	assign f7_zero = funct7 == 7'b0;
	assign f7_alt = funct7 == FUNCT7_ALT;

	// I-type sign extended, U-type upper 20 bits
	assign imm_i = {{(XLEN-12){inst_word[31]}}, inst_word[31:20]};
	assign imm_u = {inst_word[31:12], 12'b0};

	always_comb begin
		dec_alu = ALU_PASS_B;
		dec_imm = imm_i;
		dec_rs1 = inst_word[19:15];
		dec_use_imm = 1'b1;
		dec_use_pc = 1'b0;
		dec_illegal = 1'b0;
		case (opcode)
			OPC_LUI: begin
				dec_imm = imm_u;
				dec_rs1 = '0;
			end
			OPC_AUIPC: begin
				dec_alu = ALU_ADD;
				dec_imm = imm_u;
				dec_use_pc = 1'b1;
			end
			OPC_OP_IMM: begin
				// Only shifts carry funct7 in the immediate
				dec_alu = f3_to_alu(funct3, f7_alt && funct3 == F3_SRL);
				if (funct3 == F3_SLL && !f7_zero)
					dec_illegal = 1'b1;
				if (funct3 == F3_SRL && !(f7_zero || f7_alt))
					dec_illegal = 1'b1;
			end
			OPC_OP: begin
				dec_alu = f3_to_alu(funct3, f7_alt);
				dec_use_imm = 1'b0;
				if (!(f7_zero || (f7_alt && (funct3 == F3_ADD || funct3 == F3_SRL))))
					dec_illegal = 1'b1;
			end
			default: dec_illegal = 1'b1;
		endcase
	end

	assign accept = !inst_ack && inst_req && !full;

	// Intake handshake and PC counter
	always_ff @(posedge clk) begin
		if (reset) begin
			inst_ack <= 1'b0;
			push <= 1'b0;
			pc <= '0;
		end else begin
			push <= accept;
			if (accept) begin
				inst_ack <= 1'b1;
				pc <= pc + XLEN'(4);
			end else if (inst_ack && !inst_req) begin
				inst_ack <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			op_pc <= pc;
			op_rd <= inst_word[11:7];
			op_rs1 <= dec_rs1;
			op_rs2 <= inst_word[24:20];
			op_imm <= dec_imm;
			op_alu <= dec_alu;
			op_use_imm <= dec_use_imm;
			op_use_pc <= dec_use_pc;
			op_illegal <= dec_illegal;
		end
	end

	ack_follows_req: assert property (@(posedge clk) disable iff (reset)
		$rose(inst_ack) |-> $past(inst_req));

endmodule

// ==== design/decode_fifo.sv ====
`timescale 1ns/1ps

module decode_fifo import rv_isa_pkg::*, core_pkg::*; #(
	parameter int DEPTH = FIFO_DEPTH
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  push,
	input  logic                  pop,
	output logic                  full,
	output logic                  empty,
	input  logic [XLEN-1:0]       in_pc,
	input  logic [REG_ADDR_W-1:0] in_rd,
	input  logic [REG_ADDR_W-1:0] in_rs1,
	input  logic [REG_ADDR_W-1:0] in_rs2,
	input  logic [XLEN-1:0]       in_imm,
	input  alu_op_e               in_alu,
	input  logic                  in_use_imm,
	input  logic                  in_use_pc,
	input  logic                  in_illegal,
	output logic [XLEN-1:0]       head_pc,
	output logic [REG_ADDR_W-1:0] head_rd,
	output logic [REG_ADDR_W-1:0] head_rs1,
	output logic [REG_ADDR_W-1:0] head_rs2,
	output logic [XLEN-1:0]       head_imm,
	output alu_op_e               head_alu,
	output logic                  head_use_imm,
	output logic                  head_use_pc,
	output logic                  head_illegal
);

	logic [XLEN-1:0] pc_mem [DEPTH];
	logic [REG_ADDR_W-1:0] rd_mem [DEPTH];
	logic [REG_ADDR_W-1:0] rs1_mem [DEPTH];
	logic [REG_ADDR_W-1:0] rs2_mem [DEPTH];
	logic [XLEN-1:0] imm_mem [DEPTH];
	alu_op_e alu_mem [DEPTH];
	logic [2:0] flag_mem [DEPTH];

	logic [FIFO_PTR_W-1:0] wr_ptr;
	logic [FIFO_PTR_W-1:0] rd_ptr;
	logic [FIFO_PTR_W:0] count;

	assign full = count == (FIFO_PTR_W + 1)'(DEPTH);
	assign empty = count == '0;

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == FIFO_PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + FIFO_PTR_W'(1);
			if (pop)
				rd_ptr <= (rd_ptr == FIFO_PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + FIFO_PTR_W'(1);
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			pc_mem[wr_ptr] <= in_pc;
			rd_mem[wr_ptr] <= in_rd;
			rs1_mem[wr_ptr] <= in_rs1;
			rs2_mem[wr_ptr] <= in_rs2;
			imm_mem[wr_ptr] <= in_imm;
			alu_mem[wr_ptr] <= in_alu;
			flag_mem[wr_ptr] <= {in_use_imm, in_use_pc, in_illegal};
		end
	end

	// Head entry is visible before the pop
	assign head_pc = pc_mem[rd_ptr];
	assign head_rd = rd_mem[rd_ptr];
	assign head_rs1 = rs1_mem[rd_ptr];
	assign head_rs2 = rs2_mem[rd_ptr];
	assign head_imm = imm_mem[rd_ptr];
	assign head_alu = alu_mem[rd_ptr];
	assign {head_use_imm, head_use_pc, head_illegal} = flag_mem[rd_ptr];

	no_overflow: assert property (@(posedge clk) disable iff (reset) push |-> !full);
	no_underflow: assert property (@(posedge clk) disable iff (reset) pop |-> !empty);

endmodule

// ==== design/exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit import rv_isa_pkg::*, core_pkg::*; (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  empty,
	output logic                  pop,
	input  logic [XLEN-1:0]       head_pc,
	input  logic [REG_ADDR_W-1:0] head_rd,
	input  logic [REG_ADDR_W-1:0] head_rs1,
	input  logic [REG_ADDR_W-1:0] head_rs2,
	input  logic [XLEN-1:0]       head_imm,
	input  alu_op_e               head_alu,
	input  logic                  head_use_imm,
	input  logic                  head_use_pc,
	input  logic                  head_illegal,
	output logic                  ret_req,
	input  logic                  ret_ack,
	output logic [XLEN-1:0]       ret_pc,
	output logic [REG_ADDR_W-1:0] ret_rd,
	output logic [XLEN-1:0]       ret_value,
	output logic                  ret_illegal
);

	exec_state_e state;

	logic [XLEN-1:0] rdata1;
	logic [XLEN-1:0] rdata2;
	logic [XLEN-1:0] alu_a;
	logic [XLEN-1:0] alu_b;
	logic [XLEN-1:0] alu_result;

	assign pop = (state == IDLE) && !empty;
	assign ret_req = state == REQ;

	assign alu_a = head_use_pc ? head_pc : rdata1;
	assign alu_b = head_use_imm ? head_imm : rdata2;

	reg_file u_reg_file (
		.clk(clk),
		.reset(reset),
		.rs1(head_rs1),
		.rs2(head_rs2),
		.rdata1(rdata1),
		.rdata2(rdata2),
		.we(pop && !head_illegal),
		.waddr(head_rd),
		.wdata(alu_result)
	);

	alu u_alu (
		.op(head_alu),
		.a(alu_a),
		.b(alu_b),
		.result(alu_result)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: if (pop) state <= REQ;
				REQ: if (ret_ack) state <= WAIT_LOW;
				WAIT_LOW: if (!ret_ack) state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	// Result is latched on the same edge as the register write
	always_ff @(posedge clk) begin
		if (pop) begin
			ret_pc <= head_pc;
			ret_rd <= head_rd;
			ret_value <= head_illegal ? '0 : alu_result;
			ret_illegal <= head_illegal;
		end
	end

	ret_stable: assert property (@(posedge clk) disable iff (reset)
		ret_req && !ret_ack |=> ret_req && $stable({ret_pc, ret_rd, ret_value, ret_illegal}));

endmodule

// ==== design/rv_core.sv ====
`timescale 1ns/1ps

module rv_core import rv_isa_pkg::*, core_pkg::*; (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  inst_req,
	input  logic [XLEN-1:0]       inst_word,
	output logic                  inst_ack,
	output logic                  ret_req,
	input  logic                  ret_ack,
	output logic [XLEN-1:0]       ret_pc,
	output logic [REG_ADDR_W-1:0] ret_rd,
	output logic [XLEN-1:0]       ret_value,
	output logic                  ret_illegal
);

	logic push, pop, full, empty;

	// Decoder to FIFO
	logic [XLEN-1:0] op_pc, op_imm;
	logic [REG_ADDR_W-1:0] op_rd, op_rs1, op_rs2;
	alu_op_e op_alu;
	logic op_use_imm, op_use_pc, op_illegal;

	// FIFO head to execute unit
	logic [XLEN-1:0] head_pc, head_imm;
	logic [REG_ADDR_W-1:0] head_rd, head_rs1, head_rs2;
	alu_op_e head_alu;
	logic head_use_imm, head_use_pc, head_illegal;

	inst_decoder u_decoder (
		.clk(clk), .reset(reset),
		.inst_req(inst_req), .inst_word(inst_word), .inst_ack(inst_ack),
		.full(full), .push(push),
		.op_pc(op_pc), .op_rd(op_rd), .op_rs1(op_rs1), .op_rs2(op_rs2),
		.op_imm(op_imm), .op_alu(op_alu), .op_use_imm(op_use_imm),
		.op_use_pc(op_use_pc), .op_illegal(op_illegal)
	);

	decode_fifo #(.DEPTH(FIFO_DEPTH)) u_fifo (
		.clk(clk), .reset(reset),
		.push(push), .pop(pop), .full(full), .empty(empty),
		.in_pc(op_pc), .in_rd(op_rd), .in_rs1(op_rs1), .in_rs2(op_rs2),
		.in_imm(op_imm), .in_alu(op_alu), .in_use_imm(op_use_imm),
		.in_use_pc(op_use_pc), .in_illegal(op_illegal),
		.head_pc(head_pc), .head_rd(head_rd), .head_rs1(head_rs1), .head_rs2(head_rs2),
		.head_imm(head_imm), .head_alu(head_alu), .head_use_imm(head_use_imm),
		.head_use_pc(head_use_pc), .head_illegal(head_illegal)
	);

	exec_unit u_exec (
		.clk(clk), .reset(reset),
		.empty(empty), .pop(pop),
		.head_pc(head_pc), .head_rd(head_rd), .head_rs1(head_rs1), .head_rs2(head_rs2),
		.head_imm(head_imm), .head_alu(head_alu), .head_use_imm(head_use_imm),
		.head_use_pc(head_use_pc), .head_illegal(head_illegal),
		.ret_req(ret_req), .ret_ack(ret_ack),
		.ret_pc(ret_pc), .ret_rd(ret_rd), .ret_value(ret_value), .ret_illegal(ret_illegal)
	);

endmodule

// ==== test/tb_rv_core.sv ====
`timescale 1ns/1ps

module tb_rv_core import rv_isa_pkg::*, core_pkg::*; ;

	localparam int MAX_LINES = 64;
	localparam int BP_WORDS = FIFO_DEPTH + 2;
	localparam int ACK_LIMIT = 100;
	localparam logic [XLEN-1:0] END_MARK = '1;

	logic clk;
	logic reset;
	logic inst_req;
	logic [XLEN-1:0] inst_word;
	logic inst_ack;
	logic ret_req;
	logic ret_ack;
	logic [XLEN-1:0] ret_pc;
	logic [REG_ADDR_W-1:0] ret_rd;
	logic [XLEN-1:0] ret_value;
	logic ret_illegal;

	// Four entries per line of the golden file
	logic [XLEN-1:0] golden [4*MAX_LINES];
	int num_lines;
	int retired;
	logic hold_ack;
	int seed;

	rv_core u_dut (
		.clk(clk), .reset(reset),
		.inst_req(inst_req), .inst_word(inst_word), .inst_ack(inst_ack),
		.ret_req(ret_req), .ret_ack(ret_ack),
		.ret_pc(ret_pc), .ret_rd(ret_rd), .ret_value(ret_value), .ret_illegal(ret_illegal)
	);

	always #4 clk = ~clk;

	task automatic fail_run();
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	// Inputs change and outputs are read 1 ns after the rising edge
	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic compare_word(input string name, input logic [XLEN-1:0] got,
			input logic [XLEN-1:0] exp);
		if (got !== exp) begin
			$display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
			fail_run();
		end
	endtask

	task automatic compare_reg(input string name, input logic [REG_ADDR_W-1:0] got,
			input logic [REG_ADDR_W-1:0] exp);
		if (got !== exp) begin
			$display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
			fail_run();
		end
	endtask

	task automatic compare_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
			fail_run();
		end
	endtask

	task automatic check_retire(input int idx);
		compare_word("ret_pc", ret_pc, XLEN'(4 * idx));
		compare_reg("ret_rd", ret_rd, golden[4*idx+1][REG_ADDR_W-1:0]);
		compare_word("ret_value", ret_value, golden[4*idx+2]);
		compare_flag("ret_illegal", ret_illegal, golden[4*idx+3][0]);
	endtask

	task automatic finish_word();
		int waited;
		waited = 0;
		while (!inst_ack) begin
			step();
			waited++;
			if (waited > ACK_LIMIT) begin
				$display("no inst_ack within %0d cycles of inst_req", ACK_LIMIT);
				fail_run();
			end
		end
		inst_req = 1'b0;
		while (inst_ack)
			step();
	endtask

	task automatic send_word(input logic [XLEN-1:0] word);
		inst_word = word;
		inst_req = 1'b1;
		finish_word();
	endtask

	initial begin : host_side
		int n;
		int n_normal;
		clk = 1'b0;
		reset = 1'b1;
		inst_req = 1'b0;
		inst_word = '0;
		ret_ack = 1'b0;
		hold_ack = 1'b0;
		retired = 0;
		seed = 25;
		num_lines = 0;
		$readmemh("test/rv_core_golden.txt", golden);
		n = 0;
		while (n < MAX_LINES && golden[4*n] !== END_MARK)
			n++;
		if (n <= BP_WORDS || n == MAX_LINES) begin
			$display("golden file is missing, too short or has no end marker");
			fail_run();
		end
		num_lines = n;
		n_normal = n - BP_WORDS;
		repeat (10) @(posedge clk);
		#1 reset = 1'b0;

		for (int i = 0; i < n_normal; i++)
			send_word(golden[4*i]);
		while (retired < n_normal)
			step();

		// Retire acks withheld so the FIFO and execute unit fill up
		hold_ack = 1'b1;
		for (int i = n_normal; i < n - 1; i++)
			send_word(golden[4*i]);
		inst_word = golden[4*(n-1)];
		inst_req = 1'b1;
		repeat (50) begin
			step();
			if (inst_ack) begin
				$display("inst_ack rose while the FIFO and execute unit were both occupied");
				fail_run();
			end
		end
		hold_ack = 1'b0;
		finish_word();

		while (retired < num_lines)
			step();
		$display("NO ERRORS");
		$finish;
	end

	initial begin : retire_side
		int delay;
		forever begin
			step();
			if (ret_req) begin
				if (retired >= num_lines) begin
					$display("a retire arrived with no golden line left to match it");
					fail_run();
				end
				check_retire(retired);
				delay = $unsigned($random(seed)) % 4;
				repeat (delay) step();
				while (hold_ack)
					step();
				ret_ack = 1'b1;
				while (ret_req)
					step();
				ret_ack = 1'b0;
				retired++;
			end
		end
	end

	initial begin : watchdog
		int limit;
		wait (num_lines > 0);
		limit = 200 * num_lines + 500 + 10;
		repeat (limit) @(posedge clk);
		$display("timeout after %0d cycles with %0d of %0d retired", limit, retired, num_lines);
		fail_run();
	end

endmodule

// ==== rv_core.f ====
design/rv_isa_pkg.sv
design/core_pkg.sv
design/alu.sv
design/reg_file.sv
design/inst_decoder.sv
design/decode_fifo.sv
design/exec_unit.sv
design/rv_core.sv
test/tb_rv_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_rv_core
FILELIST ?= rv_core.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "NO ERRORS" $(LOG); then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/rv_core_golden.txt ====
// Columns are instruction word, expected rd, expected retire value, illegal flag
// Last six lines are the back-pressure group and an all-ones word ends the list
00500093 01 00000005 0
ffd00113 02 fffffffd 0
002081b3 03 00000002 0
40208233 04 00000008 0
401102b3 05 fffffff8 0
4012d333 06 ffffffff 0
0012d3b3 07 07ffffff 0
00112433 08 00000001 0
001134b3 09 00000000 0
ffe12513 0a 00000001 0
fff0b593 0b 00000001 0
0f00c613 0c 000000f5 0
0ff17713 0e 000000fd 0
00409793 0f 00000050 0
40115813 10 fffffffe 0
123458b7 11 12345000 0
00001917 12 00001040 0
00708013 00 0000000c 0
001009b3 13 00000005 0
00002083 01 00000000 1
00008a13 14 00000005 0
00100a93 15 00000001 0
00200b13 16 00000002 0
00300b93 17 00000003 0
00400c13 18 00000004 0
00500c93 19 00000005 0
019a8d33 1a 00000006 0
ffffffff 00 00000000 0
